// ==== commit_monitor.f ====
+incdir+design
design/commit_pkg.sv
design/apb_pkg.sv
design/perf_counters.sv
design/pc_trace_queue.sv
design/monitor_regs.sv
design/commit_monitor.sv
testbench/tb_commit_monitor.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f commit_monitor.f \
		--top-module tb_commit_monitor -o tb_commit_monitor
	./obj_dir/tb_commit_monitor | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/tb_commit_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "monitor_macros.svh"

module tb_commit_monitor;

  localparam int RESET_CYCLES    = 5;
  localparam int TRAFFIC_CYCLES  = 300;
  localparam int DEBUG_CYCLES    = 100;
  localparam int BURST_CYCLES    = 20;
  localparam int SMALL_CYCLES    = 6;
  localparam int MAX_XFERS       = 300;
  // Each APB transfer takes setup, access and one idle cycle
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + TRAFFIC_CYCLES + DEBUG_CYCLES
                                   + BURST_CYCLES + SMALL_CYCLES + 3 * MAX_XFERS + 200;

  logic                                    clk_i = 1'b0;
  logic                                    rst_ni;
  logic [`NR_COMMIT_PORTS-1:0]             commit_ack_i;
  logic [`NR_COMMIT_PORTS-1:0]             commit_ex_i;
  logic [`NR_COMMIT_PORTS-1:0][`PC_W-1:0] commit_pc_i;
  logic                                    mispredict_i;
  logic                                    debug_mode_i;
  logic                                    psel_i;
  logic                                    penable_i;
  logic                                    pwrite_i;
  logic [`ADDR_W-1:0]                      paddr_i;
  logic [`DATA_W-1:0]                      pwdata_i;
  logic [`DATA_W-1:0]                      prdata_o;
  logic                                    pready_o;
  logic                                    pslverr_o;

  // Reference model state
  logic [31:0] model_cnt [4];
  logic [31:0] model_q0 [$];
  logic [31:0] model_q1 [$];
  int          rr_ptr;

  logic [31:0] lcg_state = 32'd41175;
  int          checks = 0;
  int          errors = 0;

  always #20 clk_i = ~clk_i;

  commit_monitor u_dut (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .commit_ack_i ( commit_ack_i ),
    .commit_ex_i  ( commit_ex_i  ),
    .commit_pc_i  ( commit_pc_i  ),
    .mispredict_i ( mispredict_i ),
    .debug_mode_i ( debug_mode_i ),
    .psel_i       ( psel_i       ),
    .penable_i    ( penable_i    ),
    .pwrite_i     ( pwrite_i     ),
    .paddr_i      ( paddr_i      ),
    .pwdata_i     ( pwdata_i     ),
    .prdata_o     ( prdata_o     ),
    .pready_o     ( pready_o     ),
    .pslverr_o    ( pslverr_o    )
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic void model_cycle(input logic [1:0] ack, input logic [1:0] ex,
                                      input logic [31:0] pc0, input logic [31:0] pc1,
                                      input logic misp, input logic dbg);
    int   ret;
    int   exc;
    logic drop;
    ret  = 0;
    exc  = 0;
    drop = 1'b0;
    if (ack[0] && !ex[0]) begin
      ret++;
      if (model_q0.size() == `TRACE_DEPTH) drop = 1'b1;
      else model_q0.push_back(pc0);
    end
    if (ack[1] && !ex[1]) begin
      ret++;
      if (model_q1.size() == `TRACE_DEPTH) drop = 1'b1;
      else model_q1.push_back(pc1);
    end
    if (ack[0] && ex[0]) exc++;
    if (ack[1] && ex[1]) exc++;
    // Queues keep filling in debug mode, only the counters freeze
    if (!dbg) begin
      model_cnt[0] = model_cnt[0] + 32'(ret);
      model_cnt[1] = model_cnt[1] + 32'(exc);
      model_cnt[2] = model_cnt[2] + {31'd0, misp};
      model_cnt[3] = model_cnt[3] + {31'd0, drop};
    end
  endfunction

  function automatic logic model_empty();
    return (model_q0.size() == 0) && (model_q1.size() == 0);
  endfunction

  // Round robin, first non-empty port at or after the pointer
  function automatic logic [31:0] model_pop();
    logic [31:0] pc;
    pc = '0;
    if (rr_ptr == 0) begin
      if (model_q0.size() != 0) begin
        pc     = model_q0.pop_front();
        rr_ptr = 1;
      end else if (model_q1.size() != 0) begin
        pc     = model_q1.pop_front();
        rr_ptr = 0;
      end
    end else begin
      if (model_q1.size() != 0) begin
        pc     = model_q1.pop_front();
        rr_ptr = 0;
      end else if (model_q0.size() != 0) begin
        pc     = model_q0.pop_front();
        rr_ptr = 1;
      end
    end
    return pc;
  endfunction

  // --------------------------------------------------
  // Drivers
  // --------------------------------------------------
  task automatic drive_cycle(input logic [1:0] ack, input logic [1:0] ex,
                             input logic [31:0] pc0, input logic [31:0] pc1,
                             input logic misp, input logic dbg);
    @(posedge clk_i);
    commit_ack_i   <= ack;
    commit_ex_i    <= ex;
    commit_pc_i[0] <= pc0;
    commit_pc_i[1] <= pc1;
    mispredict_i   <= misp;
    debug_mode_i   <= dbg;
    model_cycle(ack, ex, pc0, pc1, misp, dbg);
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle(2'b00, 2'b00, 32'd0, 32'd0, 1'b0, 1'b0);
    end
  endtask

  task automatic random_traffic(input int cycles, input logic dbg);
    logic [31:0] r;
    logic [1:0]  ex;
    logic [31:0] pc0;
    logic [31:0] pc1;
    for (int i = 0; i < cycles; i++) begin
      r      = lcg_next();
      ex[0]  = (r[20:18] == 3'd0);
      ex[1]  = (r[23:21] == 3'd0);
      pc0    = {lcg_next() & 32'hffff_fffc};
      pc1    = {lcg_next() & 32'hffff_fffc};
      drive_cycle(r[17:16], ex, pc0, pc1, (r[26:24] == 3'd0), dbg);
    end
    idle(1);
  endtask

  task automatic apb_xfer(input logic write, input logic [`ADDR_W-1:0] addr,
                          input logic [`DATA_W-1:0] wdata,
                          output logic [`DATA_W-1:0] rdata, output logic slverr);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    // Registered response, settled mid access cycle
    @(negedge clk_i);
    rdata  = prdata_o;
    slverr = pslverr_o;
    check("apb pready", 32'd1, {31'd0, pready_o});
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic check_counters(input string tag);
    logic [31:0] rd;
    logic        err;
    for (int i = 0; i < `NR_PERF_CNT; i++) begin
      apb_xfer(1'b0, `PERF_BASE + 12'(4 * i), '0, rd, err);
      check($sformatf("%s cnt%0d", tag, i), model_cnt[i], rd);
      check($sformatf("%s cnt%0d pslverr", tag, i), 32'd0, {31'd0, err});
    end
  endtask

  task automatic drain_trace(input string tag);
    logic [31:0] rd;
    logic        err;
    int          n;
    logic        done;
    n    = 0;
    done = 1'b0;
    while (!done && n < 2 * `TRACE_DEPTH + 4) begin
      apb_xfer(1'b0, `TRACE_STATUS_OFFS, '0, rd, err);
      check($sformatf("%s status %0d", tag, n), {31'd0, model_empty()}, rd);
      if (rd[0]) begin
        done = 1'b1;
      end else begin
        apb_xfer(1'b0, `TRACE_DATA_OFFS, '0, rd, err);
        check($sformatf("%s pc %0d", tag, n), model_pop(), rd);
        n++;
      end
    end
    check($sformatf("%s entries left", tag), 32'd0,
          32'(model_q0.size() + model_q1.size()));
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : main_seq
    logic [31:0] rd;
    logic [31:0] val;
    logic [31:0] drop_base;
    logic        err;
    for (int i = 0; i < 4; i++) model_cnt[i] = '0;
    rr_ptr = 0;
    rst_ni       <= 1'b0;
    commit_ack_i <= '0;
    commit_ex_i  <= '0;
    commit_pc_i  <= '0;
    mispredict_i <= 1'b0;
    debug_mode_i <= 1'b0;
    psel_i       <= 1'b0;
    penable_i    <= 1'b0;
    pwrite_i     <= 1'b0;
    paddr_i      <= '0;
    pwdata_i     <= '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset state
    check_counters("reset");
    apb_xfer(1'b0, `TRACE_STATUS_OFFS, '0, rd, err);
    check("reset trace status", 32'd1, rd);
    apb_xfer(1'b0, `TRACE_DATA_OFFS, '0, rd, err);
    check("reset trace data", 32'd0, rd);

    random_traffic(TRAFFIC_CYCLES, 1'b0);
    check_counters("traffic");

    // Counters must hold while the queues keep filling
    random_traffic(DEBUG_CYCLES, 1'b1);
    check_counters("debug");
    drain_trace("drain");

    // Overflow burst on port 0
    apb_xfer(1'b0, `PERF_BASE + 12'(4 * 3), '0, drop_base, err);
    for (int i = 0; i < BURST_CYCLES; i++) begin
      drive_cycle(2'b01, 2'b00, 32'h0000_1000 + 32'(4 * i), 32'd0, 1'b0, 1'b0);
    end
    idle(1);
    apb_xfer(1'b0, `PERF_BASE + 12'(4 * 3), '0, rd, err);
    check("burst drop excess", 32'(BURST_CYCLES - `TRACE_DEPTH), rd - drop_base);
    check_counters("burst");
    drain_trace("burst drain");

    // Presets read back after idle cycles
    for (int i = 0; i < `NR_PERF_CNT; i++) begin
      val = lcg_next();
      apb_xfer(1'b1, `PERF_BASE + 12'(4 * i), val, rd, err);
      check($sformatf("preset cnt%0d pslverr", i), 32'd0, {31'd0, err});
      model_cnt[i] = val;
    end
    idle(4);
    check_counters("preset");

    // Writes to the trace region fail and leave state alone
    random_traffic(SMALL_CYCLES, 1'b0);
    apb_xfer(1'b1, `TRACE_DATA_OFFS, 32'hdead_beef, rd, err);
    check("trace data write pslverr", 32'd1, {31'd0, err});
    apb_xfer(1'b1, `TRACE_STATUS_OFFS, 32'h0000_0001, rd, err);
    check("trace status write pslverr", 32'd1, {31'd0, err});
    check_counters("slverr");
    drain_trace("slverr drain");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/commit_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "monitor_macros.svh"

module commit_monitor (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic [`NR_COMMIT_PORTS-1:0]                 commit_ack_i,
  input  logic [`NR_COMMIT_PORTS-1:0]                 commit_ex_i,
  input  logic [`NR_COMMIT_PORTS-1:0][`PC_W-1:0]     commit_pc_i,
  input  logic                                        mispredict_i,
  input  logic                                        debug_mode_i,
  input  logic                                        psel_i,
  input  logic                                        penable_i,
  input  logic                                        pwrite_i,
  input  logic [`ADDR_W-1:0]                          paddr_i,
  input  logic [`DATA_W-1:0]                          pwdata_i,
  output logic [`DATA_W-1:0]                          prdata_o,
  output logic                                        pready_o,
  output logic                                        pslverr_o
);

  import commit_pkg::*;

  commit_evt_t [`NR_COMMIT_PORTS-1:0] evt;

  logic               trace_drop;
  logic               trace_empty;
  logic               trace_pop;
  logic [`PC_W-1:0]   trace_pc;
  logic               perf_wr;
  perf_idx_e          perf_idx;
  logic [`DATA_W-1:0] perf_wdata;
  logic [`DATA_W-1:0] perf_rdata;

  // Bundle each commit port for the observers
  for (genvar p = 0; p < `NR_COMMIT_PORTS; p++) begin : gen_evt
    assign evt[p].ack      = commit_ack_i[p];
    assign evt[p].ex_valid = commit_ex_i[p];
    assign evt[p].pc       = commit_pc_i[p];
  end

  perf_counters i_perf_counters (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .evt_i        ( evt          ),
    .mispredict_i ( mispredict_i ),
    .trace_drop_i ( trace_drop   ),
    .debug_mode_i ( debug_mode_i ),
    .wr_i         ( perf_wr      ),
    .idx_i        ( perf_idx     ),
    .wdata_i      ( perf_wdata   ),
    .rdata_o      ( perf_rdata   )
  );

  pc_trace_queue i_pc_trace_queue (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .evt_i   ( evt         ),
    .pop_i   ( trace_pop   ),
    .empty_o ( trace_empty ),
    .pc_o    ( trace_pc    ),
    .drop_o  ( trace_drop  )
  );

  monitor_regs i_monitor_regs (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .psel_i        ( psel_i      ),
    .penable_i     ( penable_i   ),
    .pwrite_i      ( pwrite_i    ),
    .paddr_i       ( paddr_i     ),
    .pwdata_i      ( pwdata_i    ),
    .prdata_o      ( prdata_o    ),
    .pready_o      ( pready_o    ),
    .pslverr_o     ( pslverr_o   ),
    .perf_rdata_i  ( perf_rdata  ),
    .perf_wr_o     ( perf_wr     ),
    .perf_idx_o    ( perf_idx    ),
    .perf_wdata_o  ( perf_wdata  ),
    .trace_empty_i ( trace_empty ),
    .trace_pc_i    ( trace_pc    ),
    .trace_pop_o   ( trace_pop   )
  );

endmodule

`default_nettype wire

// ==== design/monitor_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "monitor_macros.svh"

module monitor_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`ADDR_W-1:0]    paddr_i,
  input  logic [`DATA_W-1:0]    pwdata_i,
  output logic [`DATA_W-1:0]    prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  input  logic [`DATA_W-1:0]    perf_rdata_i,
  output logic                  perf_wr_o,
  output commit_pkg::perf_idx_e perf_idx_o,
  output logic [`DATA_W-1:0]    perf_wdata_o,
  input  logic                  trace_empty_i,
  input  logic [`PC_W-1:0]      trace_pc_i,
  output logic                  trace_pop_o
);

  import commit_pkg::*;
  import apb_pkg::*;

  apb_addr_u           addr;
  logic                setup;
  logic                access;
  logic                is_trace;
  logic [`DATA_W-1:0]  rdata_d;
  logic                pop_pending_q;

  assign addr     = paddr_i;
  assign setup    = psel_i && !penable_i;
  assign access   = psel_i && penable_i;
  assign is_trace = (addr.perf.region == REGION_TRACE);

  // --------------------------------------------------
  // Read data, sampled at the end of the setup cycle
  // --------------------------------------------------
  always_comb begin
    rdata_d = '0;
    if (!is_trace) begin
      rdata_d = perf_rdata_i;
    end else if (addr.trace.data_sel) begin
      rdata_d = trace_empty_i ? '0 : `DATA_W'(trace_pc_i);
    end else begin
      rdata_d = {{(`DATA_W-1){1'b0}}, trace_empty_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prdata_o      <= '0;
      pslverr_o     <= 1'b0;
      pop_pending_q <= 1'b0;
    end else begin
      pslverr_o     <= setup && pwrite_i && is_trace;
      // Only pop what the read actually returned
      pop_pending_q <= setup && !pwrite_i && is_trace && addr.trace.data_sel
                       && !trace_empty_i;
      if (setup) begin
        prdata_o <= pwrite_i ? '0 : rdata_d;
      end
    end
  end

  // Side effects in the access cycle
  assign perf_wr_o    = access && pwrite_i && !is_trace;
  assign perf_idx_o   = perf_idx_e'(addr.perf.idx);
  assign perf_wdata_o = pwdata_i;
  assign trace_pop_o  = access && pop_pending_q;

  assign pready_o = 1'b1;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(penable_i) |-> (psel_i && $past(psel_i && !penable_i)))
    else $error("APB penable raised without a setup cycle");

endmodule

`default_nettype wire

// ==== design/pc_trace_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "monitor_macros.svh"

module pc_trace_queue (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  commit_pkg::commit_evt_t [`NR_COMMIT_PORTS-1:0] evt_i,
  input  logic                                            pop_i,
  output logic                                            empty_o,
  output logic [`PC_W-1:0]                                pc_o,
  output logic                                            drop_o
);

  import commit_pkg::*;

  logic [`PC_W-1:0] mem_q [`NR_COMMIT_PORTS][`TRACE_DEPTH];

  logic [`NR_COMMIT_PORTS-1:0][`TRACE_AW-1:0] wr_ptr_q;
  logic [`NR_COMMIT_PORTS-1:0][`TRACE_AW-1:0] rd_ptr_q;
  logic [`NR_COMMIT_PORTS-1:0][`TRACE_AW:0]   cnt_q;

  logic [`NR_COMMIT_PORTS-1:0] push;
  logic [`NR_COMMIT_PORTS-1:0] do_push;
  logic [`NR_COMMIT_PORTS-1:0] full;
  logic [`NR_COMMIT_PORTS-1:0] fifo_empty;
  logic [`NR_COMMIT_PORTS-1:0] pop_fifo;

  // Round-robin state
  logic [`PORT_W-1:0] rr_q;
  logic [`PORT_W-1:0] cand;
  logic [`PORT_W-1:0] grant;
  logic               found;

  // --------------------------------------------------
  // Per-port FIFO status
  // --------------------------------------------------
  always_comb begin
    for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
      push[p]       = evt_i[p].ack && !evt_i[p].ex_valid;
      full[p]       = (cnt_q[p] == `TRACE_DEPTH);
      fifo_empty[p] = (cnt_q[p] == '0);
      do_push[p]    = push[p] && !full[p];
      pop_fifo[p]   = pop_i && found && (grant == `PORT_W'(p));
    end
  end

  // Retired PC meeting a full FIFO is lost
  assign drop_o = |(push & full);

  // --------------------------------------------------
  // Arbiter picks the first non-empty port at or after rr_q
  // --------------------------------------------------
  always_comb begin
    grant = rr_q;
    found = 1'b0;
    cand  = rr_q;
    for (int k = 0; k < `NR_COMMIT_PORTS; k++) begin
      cand = rr_q + `PORT_W'(k);
      if (!found && !fifo_empty[cand]) begin
        grant = cand;
        found = 1'b1;
      end
    end
  end

  assign empty_o = !found;
  assign pc_o    = mem_q[grant][rd_ptr_q[grant]];

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
      if (do_push[p]) begin
        mem_q[p][wr_ptr_q[p]] <= evt_i[p].pc;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      rr_q     <= '0;
    end else begin
      for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
        if (do_push[p]) begin
          wr_ptr_q[p] <= wr_ptr_q[p] + 1'b1;
        end
        if (pop_fifo[p]) begin
          rd_ptr_q[p] <= rd_ptr_q[p] + 1'b1;
        end
        unique case ({do_push[p], pop_fifo[p]})
          2'b10:   cnt_q[p] <= cnt_q[p] + 1'b1;
          2'b01:   cnt_q[p] <= cnt_q[p] - 1'b1;
          default: cnt_q[p] <= cnt_q[p];
        endcase
      end
      // Served port goes to the back of the line
      if (pop_i && found) begin
        rr_q <= grant + 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> found)
    else $error("trace pop requested while all FIFOs are empty");

  for (genvar g = 0; g < `NR_COMMIT_PORTS; g++) begin : gen_fifo_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cnt_q[g] <= `TRACE_DEPTH)
        && (cnt_q[g][`TRACE_AW-1:0] == wr_ptr_q[g] - rd_ptr_q[g]))
      else $error("trace FIFO %0d count overflow or out of step with pointers", g);
  end

endmodule

`default_nettype wire

// ==== design/perf_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "monitor_macros.svh"

module perf_counters (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  commit_pkg::commit_evt_t [`NR_COMMIT_PORTS-1:0] evt_i,
  input  logic                                            mispredict_i,
  input  logic                                            trace_drop_i,
  input  logic                                            debug_mode_i,
  input  logic                                            wr_i,
  input  commit_pkg::perf_idx_e                           idx_i,
  input  logic [`DATA_W-1:0]                              wdata_i,
  output logic [`DATA_W-1:0]                              rdata_o
);

  import commit_pkg::*;

  logic [`NR_PERF_CNT-1:0][`DATA_W-1:0] cnt_q;
  logic [`NR_PERF_CNT-1:0][`DATA_W-1:0] cnt_d;
  // Per-cycle increment, at most one per commit port
  logic [`NR_PERF_CNT-1:0][1:0]         inc;

  // --------------------------------------------------
  // Event decode
  // --------------------------------------------------
  always_comb begin
    inc = '0;
    for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
      if (evt_i[p].ack && !evt_i[p].ex_valid) begin
        inc[IDX_INSTRET] = inc[IDX_INSTRET] + 2'd1;
      end
      if (evt_i[p].ack && evt_i[p].ex_valid) begin
        inc[IDX_EXCEPTION] = inc[IDX_EXCEPTION] + 2'd1;
      end
    end
    inc[IDX_MISPREDICT] = {1'b0, mispredict_i};
    inc[IDX_TRACE_DROP] = {1'b0, trace_drop_i};
  end

  // --------------------------------------------------
  // Counter update
  // --------------------------------------------------
  always_comb begin
    cnt_d = cnt_q;
    // Frozen while the hart sits in debug mode
    if (!debug_mode_i) begin
      for (int i = 0; i < `NR_PERF_CNT; i++) begin
        cnt_d[i] = cnt_q[i] + `DATA_W'(inc[i]);
      end
    end
    // Preset wins over a same-cycle increment
    if (wr_i) begin
      cnt_d[idx_i] = wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Next-state view, so a read sampled in the APB setup cycle
  // already holds the events of that cycle
  assign rdata_o = cnt_d[idx_i];

  for (genvar g = 0; g < `NR_PERF_CNT; g++) begin : gen_mono_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      !($past(wr_i) && ($past(idx_i) == perf_idx_e'(g)))
        |-> (cnt_q[g] >= $past(cnt_q[g])))
      else $error("perf counter %0d decreased without preset", g);
  end

endmodule

`default_nettype wire

// ==== design/apb_pkg.sv ====
`default_nettype none

`include "monitor_macros.svh"

package apb_pkg;

  typedef enum logic {
    REGION_PERF  = 1'b0,
    REGION_TRACE = 1'b1
  } region_e;

  // Perf view: counter index in bits 3:2
  typedef struct packed {
    logic [2:0] rsvd_hi;
    region_e    region;
    logic [3:0] rsvd_mid;
    logic [1:0] idx;
    logic [1:0] byte_off;
  } perf_addr_t;

  // Trace view: bit 2 picks STATUS (0) or DATA (1)
  typedef struct packed {
    logic [2:0] rsvd_hi;
    region_e    region;
    logic [4:0] rsvd_mid;
    logic       data_sel;
    logic [1:0] byte_off;
  } trace_addr_t;

  typedef union packed {
    perf_addr_t  perf;
    trace_addr_t trace;
  } apb_addr_u;

endpackage

`default_nettype wire

// ==== design/commit_pkg.sv ====
`default_nettype none

`include "monitor_macros.svh"

package commit_pkg;

  // --------------------------------------------------
  // One commit port as seen by the observers
  // --------------------------------------------------
  typedef struct packed {
    logic             ack;
    logic             ex_valid;
    logic [`PC_W-1:0] pc;
  } commit_evt_t;

  // --------------------------------------------------
  // Counter slots, also the APB index in the perf region
  // --------------------------------------------------
  typedef enum logic [1:0] {
    IDX_INSTRET    = 2'd0,
    IDX_EXCEPTION  = 2'd1,
    IDX_MISPREDICT = 2'd2,
    IDX_TRACE_DROP = 2'd3
  } perf_idx_e;

endpackage

`default_nettype wire

// ==== design/monitor_macros.svh ====
`ifndef MONITOR_MACROS_SVH
`define MONITOR_MACROS_SVH

// Commit side
`define NR_COMMIT_PORTS 2
`define PORT_W          1
`define PC_W            32

// Counters and bus
`define DATA_W          32
`define ADDR_W          12
`define NR_PERF_CNT     4

// Trace FIFOs, TRACE_AW is log2 of the depth
`define TRACE_DEPTH     16
`define TRACE_AW        4

// Register map, perf counter n sits at PERF_BASE + 4*n
`define PERF_BASE         12'h000
`define TRACE_STATUS_OFFS 12'h100
`define TRACE_DATA_OFFS   12'h104

`endif
